/* common/fgyrus_pkg.sv */
// Shared package for the stereo frame analyser
// Bus and memory sizes, frame length, sample type and local-bus register map
package fgyrus_pkg;

   // Local bus
   localparam int lb_data_w      = 32;
   localparam int lb_addr_w      = 12;

   // PCM channel memories
   localparam int pcm_mem_data_w = 32;                     // One sample per word
   localparam int pcm_mem_addr_w = 7;
   localparam int frame_len      = 1 << pcm_mem_addr_w;    // 128 samples per frame

   localparam int pcm_sample_w   = 16;                     // Low half of each word

   // 128 squares of -32768 reach 2^37 with headroom to spare
   localparam int acc_w          = 39;

   // Signed PCM sample as stored in bits 15:0
   typedef logic signed [pcm_sample_w-1:0] pcm_sample_t;

   // Register map in byte addresses
   localparam logic [lb_addr_w-1:0] reg_ctrl_addr   = 12'h000;  // Bit 0 enable
   localparam logic [lb_addr_w-1:0] reg_status_addr = 12'h004;  // Busy, frame count
   localparam logic [lb_addr_w-1:0] reg_lpow_addr   = 12'h010;  // Left mean square
   localparam logic [lb_addr_w-1:0] reg_lpeak_addr  = 12'h014;  // Left peak magnitude
   localparam logic [lb_addr_w-1:0] reg_rpow_addr   = 12'h018;  // Right mean square
   localparam logic [lb_addr_w-1:0] reg_rpeak_addr  = 12'h01C;  // Right peak magnitude

   // Returned for any address outside the map
   localparam logic [lb_data_w-1:0] reg_bad_data    = 32'hDEAD_DEAD;

endpackage

/* source/fgyrus_pcm_fetch.sv */
// Frame fetch sequencer
// Issues 128 reads to both PCM memories and counts the words that return
module fgyrus_pcm_fetch
   import fgyrus_pkg::*;
(
   input  logic                      sys_clk_100,
   input  logic                      rst,
   input  logic                      enable,        // From control register
   input  logic                      pcm_rdy,       // New frame available
   output logic [pcm_mem_addr_w-1:0] mem_addr,      // Shared by both channels
   output logic                      mem_rden,
   input  logic                      mem_rd_valid,  // Marks returned words
   output logic                      busy,
   output logic                      frame_start,   // Clears the stats units
   output logic                      sample_valid,
   output logic                      frame_end      // With last returned word
);

   logic [pcm_mem_addr_w-1:0] rcv_cnt;             // Words returned so far

   // Frame accepted only when idle and enabled
   assign frame_start  = pcm_rdy & enable & ~busy;
   assign sample_valid = mem_rd_valid & busy;
   assign frame_end    = sample_valid && (rcv_cnt == pcm_mem_addr_w'(frame_len - 1));

   always_ff @(posedge sys_clk_100)
   begin
      if (rst)
      begin
         busy <= 1'b0;
      end
      else if (frame_start)
      begin
         busy <= 1'b1;                             // Rises the cycle after accept
      end
      else if (frame_end)
      begin
         busy <= 1'b0;                             // All 128 words are in
      end
   end

   // Read issue side with one request per cycle
   always_ff @(posedge sys_clk_100)
   begin
      if (rst)
      begin
         mem_rden <= 1'b0;
         mem_addr <= '0;
      end
      else if (frame_start)
      begin
         mem_rden <= 1'b1;
         mem_addr <= '0;
      end
      else if (mem_rden)
      begin
         mem_addr <= mem_addr + 1'b1;              // Wraps back to 0 at the end
         if (mem_addr == pcm_mem_addr_w'(frame_len - 1))
         begin
            mem_rden <= 1'b0;                      // Last request out
         end
      end
   end

   // Return side with up to four reads in flight
   always_ff @(posedge sys_clk_100)
   begin
      if (rst)
      begin
         rcv_cnt <= '0;
      end
      else if (frame_start)
      begin
         rcv_cnt <= '0;
      end
      else if (sample_valid)
      begin
         rcv_cnt <= rcv_cnt + 1'b1;
      end
   end

   // Requests stay inside the busy window
   assert property (@(posedge sys_clk_100) disable iff (rst) mem_rden |-> busy)
      else $error("mem_rden raised while not busy");

   // Memory returns no more words than were requested
   assert property (@(posedge sys_clk_100) disable iff (rst) mem_rd_valid |-> busy)
      else $error("mem_rd_valid after all frame words returned");

endmodule

/* source/fgyrus_chnnl_stats.sv */
// Per-channel frame statistics
// Sum of squares reduced to mean square, and peak absolute sample value
module fgyrus_chnnl_stats
   import fgyrus_pkg::*;
(
   input  logic                      sys_clk_100,
   input  logic                      rst,
   input  logic                      frame_start,   // Clears accumulators
   input  logic                      sample_valid,
   input  logic [pcm_mem_data_w-1:0] sample_word,   // Sample in low half
   input  logic                      frame_end,     // Last sample of frame
   output logic [lb_data_w-1:0]      power,         // Mean square, saturated
   output logic [lb_data_w-1:0]      peak,          // Largest magnitude
   output logic                      stats_done
);

   pcm_sample_t                 sample;
   logic [31:0]                 sample_sq;         // Square fits 2^30
   logic [pcm_sample_w-1:0]     sample_abs;        // 32768 for -32768
   logic [acc_w-1:0]            acc;
   logic [acc_w-1:0]            acc_nxt;
   logic [acc_w-1:0]            acc_mean;
   logic [pcm_sample_w-1:0]     peak_run;
   logic [pcm_sample_w-1:0]     peak_nxt;
   logic                        in_frame;

   assign sample     = pcm_sample_t'(sample_word[pcm_sample_w-1:0]);
   assign sample_sq  = sample * sample;            // Signed, 32 bit context
   assign sample_abs = sample[pcm_sample_w-1] ? pcm_sample_w'(~sample + 1'b1)
                                              : sample;
   assign acc_nxt    = acc + {{(acc_w-32){1'b0}}, sample_sq};
   assign acc_mean   = acc_nxt >> $clog2(frame_len);   // Divide by 128
   assign peak_nxt   = (sample_abs > peak_run) ? sample_abs : peak_run;

   always_ff @(posedge sys_clk_100)
   begin
      if (rst)
      begin
         acc      <= '0;
         peak_run <= '0;
         in_frame <= 1'b0;
      end
      else if (frame_start)
      begin
         acc      <= '0;
         peak_run <= '0;
         in_frame <= 1'b1;
      end
      else if (sample_valid)
      begin
         acc      <= acc_nxt;
         peak_run <= peak_nxt;
         if (frame_end)
            in_frame <= 1'b0;
      end
   end

   // Results taken from the running values including the last sample
   always_ff @(posedge sys_clk_100)
   begin
      if (rst)
      begin
         power      <= '0;
         peak       <= '0;
         stats_done <= 1'b0;
      end
      else
      begin
         stats_done <= frame_end;                  // One cycle after frame end
         if (frame_end)
         begin
            power <= (|acc_mean[acc_w-1:lb_data_w]) ? '1 : acc_mean[lb_data_w-1:0];
            peak  <= {{(lb_data_w-pcm_sample_w){1'b0}}, peak_nxt};
         end
      end
   end

   // Fetch only hands over samples between frame start and frame end
   assert property (@(posedge sys_clk_100) disable iff (rst) sample_valid |-> in_frame)
      else $error("sample_valid outside a frame");

endmodule

/* source/fgyrus_lb_regs.sv */
// Local-bus register slave
// Control, status with frame count, and latched per-channel results
module fgyrus_lb_regs
   import fgyrus_pkg::*;
(
   input  logic                 sys_clk_100,
   input  logic                 rst,
   input  logic                 lb_rd_en,
   input  logic                 lb_wr_en,
   input  logic [lb_addr_w-1:0] lb_addr,
   input  logic [lb_data_w-1:0] lb_wr_data,
   output logic                 lb_rd_valid,    // One cycle after rd_en
   output logic                 lb_wr_valid,    // One cycle after wr_en
   output logic [lb_data_w-1:0] lb_rd_data,
   input  logic                 busy,           // From fetch
   input  logic                 stats_done,     // Results ready
   input  logic [lb_data_w-1:0] lpow,
   input  logic [lb_data_w-1:0] lpeak,
   input  logic [lb_data_w-1:0] rpow,
   input  logic [lb_data_w-1:0] rpeak,
   output logic                 enable
);

   logic [15:0]          frame_cnt;             // Wraps at 16 bits
   logic [lb_data_w-1:0] lpow_q;
   logic [lb_data_w-1:0] lpeak_q;
   logic [lb_data_w-1:0] rpow_q;
   logic [lb_data_w-1:0] rpeak_q;
   logic [lb_data_w-1:0] rd_mux;

   // Busy is kept high in status until the results and count are latched
   always_comb
   begin
      case (lb_addr)
         reg_ctrl_addr:   rd_mux = {{(lb_data_w-1){1'b0}}, enable};
         reg_status_addr: rd_mux = {frame_cnt, 15'd0, busy | stats_done};
         reg_lpow_addr:   rd_mux = lpow_q;
         reg_lpeak_addr:  rd_mux = lpeak_q;
         reg_rpow_addr:   rd_mux = rpow_q;
         reg_rpeak_addr:  rd_mux = rpeak_q;
         default:         rd_mux = reg_bad_data;   // Unmapped
      endcase
   end

   // Bus handshake
   always_ff @(posedge sys_clk_100)
   begin
      if (rst)
      begin
         lb_rd_valid <= 1'b0;
         lb_wr_valid <= 1'b0;
      end
      else
      begin
         lb_rd_valid <= lb_rd_en;
         lb_wr_valid <= lb_wr_en;                 // All writes acknowledged
      end
   end

   always_ff @(posedge sys_clk_100)
   begin
      if (lb_rd_en)
      begin
         lb_rd_data <= rd_mux;
      end
   end

   // Control and result registers
   always_ff @(posedge sys_clk_100)
   begin
      if (rst)
      begin
         enable    <= 1'b0;
         frame_cnt <= '0;
         lpow_q    <= '0;
         lpeak_q   <= '0;
         rpow_q    <= '0;
         rpeak_q   <= '0;
      end
      else
      begin
         if (lb_wr_en && (lb_addr == reg_ctrl_addr))
         begin
            enable <= lb_wr_data[0];              // Only writable bit
         end
         if (stats_done)
         begin
            frame_cnt <= frame_cnt + 1'b1;
            lpow_q    <= lpow;
            lpeak_q   <= lpeak;
            rpow_q    <= rpow;
            rpeak_q   <= rpeak;
         end
      end
   end

   // Master issues one access at a time
   assert property (@(posedge sys_clk_100) disable iff (rst) !(lb_rd_en && lb_wr_en))
      else $error("lb_rd_en and lb_wr_en high together");

endmodule

/* source/fgyrus_top.sv */
// Stereo frame analyser top level
// Frame fetch, left and right statistics units, local-bus registers
module fgyrus_top
   import fgyrus_pkg::*;
(
   input  logic                      sys_clk_100,
   input  logic                      rst,
   input  logic                      pcm_rdy,       // Frame strobe
   input  logic                      lb_rd_en,
   input  logic                      lb_wr_en,
   input  logic [lb_addr_w-1:0]      lb_addr,
   input  logic [lb_data_w-1:0]      lb_wr_data,
   output logic                      lb_rd_valid,
   output logic                      lb_wr_valid,
   output logic [lb_data_w-1:0]      lb_rd_data,
   output logic [pcm_mem_addr_w-1:0] mem_addr,      // Both channel memories
   output logic                      mem_rden,
   input  logic [pcm_mem_data_w-1:0] lpcm_rdata,
   input  logic [pcm_mem_data_w-1:0] rpcm_rdata,
   input  logic                      mem_rd_valid   // Common to both channels
);

   logic                 enable;
   logic                 busy;
   logic                 frame_start;
   logic                 sample_valid;
   logic                 frame_end;
   logic                 stats_done;
   logic [lb_data_w-1:0] lpow;
   logic [lb_data_w-1:0] lpeak;
   logic [lb_data_w-1:0] rpow;
   logic [lb_data_w-1:0] rpeak;

   fgyrus_pcm_fetch u_fetch
   (
      .sys_clk_100  (sys_clk_100),
      .rst          (rst),
      .enable       (enable),
      .pcm_rdy      (pcm_rdy),
      .mem_addr     (mem_addr),
      .mem_rden     (mem_rden),
      .mem_rd_valid (mem_rd_valid),
      .busy         (busy),
      .frame_start  (frame_start),
      .sample_valid (sample_valid),
      .frame_end    (frame_end)
   );

   fgyrus_chnnl_stats lchnnl
   (
      .sys_clk_100  (sys_clk_100),
      .rst          (rst),
      .frame_start  (frame_start),
      .sample_valid (sample_valid),
      .sample_word  (lpcm_rdata),
      .frame_end    (frame_end),
      .power        (lpow),
      .peak         (lpeak),
      .stats_done   (stats_done)
   );

   // Same sample stream timing as the left channel, so its done is identical
   fgyrus_chnnl_stats rchnnl
   (
      .sys_clk_100  (sys_clk_100),
      .rst          (rst),
      .frame_start  (frame_start),
      .sample_valid (sample_valid),
      .sample_word  (rpcm_rdata),
      .frame_end    (frame_end),
      .power        (rpow),
      .peak         (rpeak),
      .stats_done   ()
   );

   fgyrus_lb_regs u_regs
   (
      .sys_clk_100  (sys_clk_100),
      .rst          (rst),
      .lb_rd_en     (lb_rd_en),
      .lb_wr_en     (lb_wr_en),
      .lb_addr      (lb_addr),
      .lb_wr_data   (lb_wr_data),
      .lb_rd_valid  (lb_rd_valid),
      .lb_wr_valid  (lb_wr_valid),
      .lb_rd_data   (lb_rd_data),
      .busy         (busy),
      .stats_done   (stats_done),
      .lpow         (lpow),
      .lpeak        (lpeak),
      .rpow         (rpow),
      .rpeak        (rpeak),
      .enable       (enable)
   );

endmodule

/* bench/fgyrus_pcm_mem_model.sv */
// Two-channel PCM memory model for the frame analyser bench
// In-order reads with 1 to 4 cycles of random latency, arrays loaded from the bench
module fgyrus_pcm_mem_model
   import fgyrus_pkg::*;
(
   input  logic                      sys_clk_100,
   input  logic                      rst,
   input  logic [pcm_mem_addr_w-1:0] mem_addr,
   input  logic                      mem_rden,
   output logic [pcm_mem_data_w-1:0] lpcm_rdata,
   output logic [pcm_mem_data_w-1:0] rpcm_rdata,
   output logic                      mem_rd_valid   // One word per cycle at most
);

   logic [pcm_mem_data_w-1:0] lmem [frame_len];     // Written by the bench
   logic [pcm_mem_data_w-1:0] rmem [frame_len];
   int addr_q [$];                                  // Pending read addresses
   int due_q [$];                                   // Cycle each read returns
   int cyc;
   int last_due;

   always @(posedge sys_clk_100)
   begin : model
      int due;
      int idx;
      if (rst)
      begin
         cyc = 0;
         last_due = 0;
         addr_q.delete();
         due_q.delete();
         mem_rd_valid <= 1'b0;
         lpcm_rdata   <= '0;
         rpcm_rdata   <= '0;
      end
      else
      begin
         cyc = cyc + 1;
         mem_rd_valid <= 1'b0;
         if (due_q.size() != 0 && due_q[0] == cyc)
         begin
            idx = addr_q.pop_front();
            due = due_q.pop_front();
            mem_rd_valid <= 1'b1;
            lpcm_rdata   <= lmem[idx];
            rpcm_rdata   <= rmem[idx];
         end
         if (mem_rden)
         begin
            due = cyc + int'($urandom_range(1, 4));
            if (due <= last_due)
               due = last_due + 1;                 // Keeps return order
            addr_q.push_back(int'(mem_addr));
            due_q.push_back(due);
            last_due = due;
         end
      end
   end

endmodule

/* bench/fgyrus_tb.sv */
// Testbench for the stereo frame analyser
// Clock, reset, local-bus tasks, reference model and directed tests
module fgyrus_tb;
   import fgyrus_pkg::*;

   logic                      clk = 1'b0;
   logic                      rst;
   logic                      pcm_rdy;
   logic                      lb_rd_en;
   logic                      lb_wr_en;
   logic [lb_addr_w-1:0]      lb_addr;
   logic [lb_data_w-1:0]      lb_wr_data;
   logic                      lb_rd_valid;
   logic                      lb_wr_valid;
   logic [lb_data_w-1:0]      lb_rd_data;
   logic [pcm_mem_addr_w-1:0] mem_addr;
   logic                      mem_rden;
   logic [pcm_mem_data_w-1:0] lpcm_rdata;
   logic [pcm_mem_data_w-1:0] rpcm_rdata;
   logic                      mem_rd_valid;

   pcm_sample_t lsmp [frame_len];                   // Reference copies of the frame
   pcm_sample_t rsmp [frame_len];
   int err_cnt = 0;
   int test_cnt = 0;
   int fail_tests = 0;
   int exp_frames = 0;
   int rden_cnt = 0;                                // Reads issued in current frame

   always #5 clk = ~clk;                            // 10 unit period

   fgyrus_top UUT
   (
      .sys_clk_100 (clk),          .rst         (rst),
      .pcm_rdy     (pcm_rdy),      .lb_rd_en    (lb_rd_en),
      .lb_wr_en    (lb_wr_en),     .lb_addr     (lb_addr),
      .lb_wr_data  (lb_wr_data),   .lb_rd_valid (lb_rd_valid),
      .lb_wr_valid (lb_wr_valid),  .lb_rd_data  (lb_rd_data),
      .mem_addr    (mem_addr),     .mem_rden    (mem_rden),
      .lpcm_rdata  (lpcm_rdata),   .rpcm_rdata  (rpcm_rdata),
      .mem_rd_valid(mem_rd_valid)
   );

   fgyrus_pcm_mem_model u_mem
   (
      .sys_clk_100 (clk),          .rst         (rst),
      .mem_addr    (mem_addr),     .mem_rden    (mem_rden),
      .lpcm_rdata  (lpcm_rdata),   .rpcm_rdata  (rpcm_rdata),
      .mem_rd_valid(mem_rd_valid)
   );

   // Read requests walk addresses 0 to 127 once per frame
   always @(posedge clk)
   begin
      if (!rst && mem_rden)
      begin
         assert (mem_addr === pcm_mem_addr_w'(rden_cnt))
         else
         begin
            $display("** Error: mem_addr = 0x%02h, expected 0x%02h", mem_addr,
                     rden_cnt[pcm_mem_addr_w-1:0]);
            err_cnt++;
         end
         rden_cnt = (rden_cnt + 1) % frame_len;
      end
   end

   task automatic stop_on_timeout(input string what);
      $display("Timeout: %s", what);
      $display("Something failed");
      $finish;
   endtask

   task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
      assert (got === exp)
      else
      begin
         $display("** Error: %s = 0x%08h, expected 0x%08h", name, got, exp);
         err_cnt++;
      end
   endtask

   task automatic lb_write(input logic [lb_addr_w-1:0] addr, input logic [lb_data_w-1:0] data);
      int n;
      @(posedge clk);
      #1;
      lb_wr_en   = 1'b1;
      lb_addr    = addr;
      lb_wr_data = data;
      @(posedge clk);
      #1;
      lb_wr_en = 1'b0;
      n = 0;
      while (!lb_wr_valid && n < 16)
      begin
         @(posedge clk);
         #1;
         n++;
      end
      if (!lb_wr_valid)
         stop_on_timeout("no lb_wr_valid after write strobe");
      else
         check_eq("lb_wr_valid_delay", 32'(n), 32'd0);  // Exactly one cycle
   endtask

   task automatic lb_read(input logic [lb_addr_w-1:0] addr, output logic [lb_data_w-1:0] data);
      int n;
      @(posedge clk);
      #1;
      lb_rd_en = 1'b1;
      lb_addr  = addr;
      @(posedge clk);
      #1;
      lb_rd_en = 1'b0;
      n = 0;
      while (!lb_rd_valid && n < 16)
      begin
         @(posedge clk);
         #1;
         n++;
      end
      if (!lb_rd_valid)
         stop_on_timeout("no lb_rd_valid after read strobe");
      else
      begin
         check_eq("lb_rd_valid_delay", 32'(n), 32'd0);  // Exactly one cycle
         data = lb_rd_data;                        // Valid while rd_valid high
      end
   endtask

   // Polls status until busy clears
   task automatic wait_idle(output logic [31:0] status);
      int polls;
      polls = 0;
      lb_read(reg_status_addr, status);
      while (status[0] && polls < 200)
      begin
         lb_read(reg_status_addr, status);
         polls++;
      end
      if (status[0])
         stop_on_timeout("busy still set after status polling");
   endtask

   task automatic pulse_pcm_rdy();
      @(posedge clk);
      #1;
      pcm_rdy = 1'b1;
      @(posedge clk);
      #1;
      pcm_rdy = 1'b0;
   endtask

   // Ramp left, full-scale negative right, or random on both
   task automatic load_frame(input bit random_fill);
      for (int i = 0; i < frame_len; i++)
      begin
         lsmp[i] = random_fill ? pcm_sample_t'($urandom) : pcm_sample_t'(i * 256 - 16384);
         rsmp[i] = random_fill ? pcm_sample_t'($urandom) : pcm_sample_t'(16'h8000);
         u_mem.lmem[i] = {16'($urandom), lsmp[i]};  // Upper half is noise
         u_mem.rmem[i] = {16'($urandom), rsmp[i]};
      end
   endtask

   // Mean square over the frame, saturated to 32 bits
   function automatic logic [31:0] ref_power(input bit right);
      longint sum;
      int s;
      sum = 0;
      for (int i = 0; i < frame_len; i++)
      begin
         s = right ? int'(rsmp[i]) : int'(lsmp[i]);
         sum += longint'(s) * longint'(s);
      end
      sum = sum / frame_len;
      return (sum > 64'hFFFF_FFFF) ? 32'hFFFF_FFFF : sum[31:0];
   endfunction

   function automatic logic [31:0] ref_peak(input bit right);
      int s;
      int best;
      best = 0;
      for (int i = 0; i < frame_len; i++)
      begin
         s = right ? int'(rsmp[i]) : int'(lsmp[i]);
         if (s < 0)
            s = -s;
         if (s > best)
            best = s;
      end
      return best;
   endfunction

   task automatic check_results(input logic [31:0] status);
      logic [31:0] rd;
      check_eq("frame_count", {16'd0, status[31:16]}, 32'(exp_frames & 16'hFFFF));
      lb_read(reg_lpow_addr, rd);
      check_eq("lpow", rd, ref_power(1'b0));
      lb_read(reg_lpeak_addr, rd);
      check_eq("lpeak", rd, ref_peak(1'b0));
      lb_read(reg_rpow_addr, rd);
      check_eq("rpow", rd, ref_power(1'b1));
      lb_read(reg_rpeak_addr, rd);
      check_eq("rpeak", rd, ref_peak(1'b1));
   endtask

   task automatic run_frame(input bit random_fill);
      logic [31:0] status;
      load_frame(random_fill);
      pulse_pcm_rdy();
      wait_idle(status);
      exp_frames++;
      check_results(status);
   endtask

   task automatic end_test(input string name, input int errs_at_start);
      test_cnt++;
      if (err_cnt == errs_at_start)
         $display("%s: passed", name);
      else
      begin
         $display("%s: FAILED with %0d errors", name, err_cnt - errs_at_start);
         fail_tests++;
      end
   endtask

   task automatic read_reset_values();
      logic [31:0] rd;
      int e;
      e = err_cnt;
      lb_read(reg_ctrl_addr, rd);
      check_eq("ctrl", rd, 32'h0);
      lb_read(reg_status_addr, rd);
      check_eq("status", rd, 32'h0);
      lb_read(reg_lpow_addr, rd);
      check_eq("lpow", rd, 32'h0);
      lb_read(reg_lpeak_addr, rd);
      check_eq("lpeak", rd, 32'h0);
      lb_read(reg_rpow_addr, rd);
      check_eq("rpow", rd, 32'h0);
      lb_read(reg_rpeak_addr, rd);
      check_eq("rpeak", rd, 32'h0);
      lb_read(12'h100, rd);                        // Unmapped
      check_eq("unmapped", rd, 32'hDEAD_DEAD);
      end_test("reset values", e);
   endtask

   task automatic access_ctrl_reg();
      logic [31:0] rd;
      int e;
      e = err_cnt;
      lb_write(reg_ctrl_addr, 32'h1);
      lb_read(reg_ctrl_addr, rd);
      check_eq("ctrl", rd, 32'h1);
      lb_write(reg_lpow_addr, 32'h1234_5678);      // Read-only register
      lb_read(reg_lpow_addr, rd);
      check_eq("lpow", rd, 32'h0);
      end_test("control access", e);
   endtask

   task automatic strobe_while_disabled();
      logic [31:0] rd;
      int e;
      e = err_cnt;
      lb_write(reg_ctrl_addr, 32'h0);
      pulse_pcm_rdy();
      lb_read(reg_status_addr, rd);
      check_eq("status", rd, 32'h0);               // Not busy, no frame counted
      lb_write(reg_ctrl_addr, 32'h1);
      end_test("disabled strobe", e);
   endtask

   task automatic known_frame_stats();
      logic [31:0] rd;
      int e;
      e = err_cnt;
      run_frame(1'b0);
      lb_read(reg_rpeak_addr, rd);
      check_eq("rpeak", rd, 32'h0000_8000);        // Magnitude of -32768
      lb_read(reg_status_addr, rd);
      check_eq("frame_count", {16'd0, rd[31:16]}, 32'd1);
      end_test("known frame", e);
   endtask

   task automatic random_frame_stats();
      int e;
      e = err_cnt;
      for (int f = 0; f < 4; f++)
         run_frame(1'b1);
      end_test("random frames", e);
   endtask

   task automatic strobe_while_busy();
      logic [31:0] status;
      int e;
      e = err_cnt;
      load_frame(1'b1);
      pulse_pcm_rdy();
      repeat (10) @(posedge clk);
      lb_read(reg_status_addr, status);
      check_eq("busy", {31'd0, status[0]}, 32'h1);
      pulse_pcm_rdy();                             // Second strobe mid-frame
      wait_idle(status);
      exp_frames++;
      check_results(status);
      end_test("strobe while busy", e);
   endtask

   initial
   begin
      void'($urandom(16105));
      rst        = 1'b1;
      pcm_rdy    = 1'b0;
      lb_rd_en   = 1'b0;
      lb_wr_en   = 1'b0;
      lb_addr    = '0;
      lb_wr_data = '0;
      repeat (5) @(posedge clk);
      #1;
      rst = 1'b0;
      read_reset_values();
      access_ctrl_reg();
      strobe_while_disabled();
      known_frame_stats();
      random_frame_stats();
      strobe_while_busy();
      $display("Tests %0d, failed %0d, errors %0d", test_cnt, fail_tests, err_cnt);
      if (err_cnt == 0)
         $display("Everything OK");
      else
         $display("Something failed");
      $finish;
   end

endmodule

/* filelist.f */
common/fgyrus_pkg.sv
source/fgyrus_pcm_fetch.sv
source/fgyrus_chnnl_stats.sv
source/fgyrus_lb_regs.sv
source/fgyrus_top.sv
bench/fgyrus_pcm_mem_model.sv
bench/fgyrus_tb.sv

/* Makefile */
TOP = fgyrus_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -Wall -f filelist.f --top-module $(TOP)

obj_dir/V$(TOP): filelist.f common/*.sv source/*.sv bench/*.sv
	verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module $(TOP)

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "Something failed" sim.log; then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "Everything OK" sim.log; then echo "Simulation did not finish"; exit 1; fi

clean:
	rm -rf obj_dir sim.log
